//--- common/rob_pkg.sv
`default_nettype none

package rob_pkg;

  // ##################################################
  // widths and buffer depth
  // ##################################################

  localparam int xlen      = 32;             // data and address width.
  localparam int rob_depth = 16;             // records in the buffer.
  localparam int rob_ptr_w = 4;              // log2 of rob_depth.
  localparam int cnt_w     = rob_ptr_w + 1;  // occupancy, 0 up to rob_depth.
  localparam int areg_w    = 5;              // architectural register number.

  // ##################################################
  // encodings
  // ##################################################

  // a record moves empty_slot -> waiting -> completed -> empty_slot,
  // or to ignore when a jump it depends on was mispredicted.
  typedef enum logic [1:0] {
    empty_slot = 2'd0,
    waiting    = 2'd1,  // issued, result not back yet.
    completed  = 2'd2,  // result stored, may retire.
    ignore     = 2'd3   // flushed, popped without commit.
  } rob_status_e;

  // class presented on an issue port.
  typedef enum logic [1:0] {
    none = 2'd0,  // nothing issued this cycle.
    alu  = 2'd1,
    mem  = 2'd2,  // writes go to the cache on commit.
    jump = 2'd3   // resolved at retirement.
  } instr_class_e;

endpackage

`default_nettype wire

//--- reorder_buffer/commit_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module commit_arbiter (
  input  logic global_bus,
  input  logic rst,
  input  logic head_request,
  input  logic commit_busy [2],
  output logic bus_granted,
  output logic bus_selected
);

  logic last_bus;  // bus of the most recent grant.
  logic any_free;

  // ##################################################
  // grant
  // ##################################################

  assign any_free    = !(commit_busy[0] && commit_busy[1]);
  assign bus_granted = head_request && any_free;

  always_comb begin
    if (commit_busy[0]) begin
      bus_selected = 1'b1;  // only bus 1 free.
    end else if (commit_busy[1]) begin
      bus_selected = 1'b0;  // only bus 0 free.
    end else begin
      bus_selected = !last_bus;  // both free, rotate.
    end
  end

  // ##################################################
  // round-robin pointer
  // ##################################################

  // starts at 1 so that bus 0 wins the first tie.
  always_ff @(posedge global_bus) begin
    if (rst) begin
      last_bus <= 1'b1;
    end else if (bus_granted) begin
      last_bus <= bus_selected;
    end
  end

endmodule

`default_nettype wire

//--- reorder_buffer/jump_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module jump_resolver (
  input  logic                     global_bus,
  input  logic                     rst,
  input  logic                     bus_granted,
  input  logic                     head_is_jump,
  input  logic [rob_pkg::xlen-1:0] head_pc,
  input  logic [rob_pkg::xlen-1:0] head_target,
  output logic                     mispredict,
  output logic                     redirect_valid,
  output logic [rob_pkg::xlen-1:0] redirect_pc,
  output logic                     clear_tag,
  output logic                     delete_tag
);
  import rob_pkg::*;

  logic [xlen-1:0] fall_through;
  logic            jump_retiring;

  // ##################################################
  // decision
  // ##################################################

  // fetch always predicts not taken.
  assign fall_through  = head_pc + xlen'(4);
  assign jump_retiring = bus_granted && head_is_jump;
  assign mispredict    = jump_retiring && (head_target != fall_through);

  // ##################################################
  // strobes, aligned with commit_valid
  // ##################################################

  always_ff @(posedge global_bus) begin
    if (rst) begin
      redirect_valid <= 1'b0;
      redirect_pc    <= '0;
      clear_tag      <= 1'b0;
      delete_tag     <= 1'b0;
    end else begin
      redirect_valid <= mispredict;
      redirect_pc    <= mispredict ? head_target : '0;  // zero when idle.
      delete_tag     <= mispredict;
      clear_tag      <= jump_retiring && !mispredict;
    end
  end

endmodule

`default_nettype wire

//--- reorder_buffer/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
  input  logic                       global_bus,
  input  logic                       rst,
  input  rob_pkg::instr_class_e      issue_class [2],
  input  logic [rob_pkg::xlen-1:0]   issue_pc [2],
  input  logic [rob_pkg::areg_w-1:0] issue_rd [2],
  input  logic                       issue_writes [2],
  input  logic                       issue_spec [2],
  input  logic                       cdb_valid [2],
  input  logic [rob_pkg::xlen-1:0]   cdb_pc [2],
  input  logic [rob_pkg::xlen-1:0]   cdb_result [2],
  input  logic [rob_pkg::xlen-1:0]   cdb_jmp_target [2],
  input  logic                       commit_busy [2],
  output logic                       commit_valid [2],
  output logic [rob_pkg::xlen-1:0]   commit_pc [2],
  output logic [rob_pkg::xlen-1:0]   commit_result [2],
  output logic [rob_pkg::areg_w-1:0] commit_rd [2],
  output logic                       commit_reg_write [2],
  output logic                       commit_mem_write [2],
  output logic                       redirect_valid,
  output logic [rob_pkg::xlen-1:0]   redirect_pc,
  output logic                       clear_tag,
  output logic                       delete_tag,
  output logic                       full
);
  import rob_pkg::*;

  rob_status_e      rec_status [rob_depth];
  logic             rec_spec   [rob_depth];
  instr_class_e     rec_class  [rob_depth];
  logic [xlen-1:0]  rec_pc     [rob_depth];
  logic [xlen-1:0]  rec_result [rob_depth];
  logic [xlen-1:0]  rec_target [rob_depth];
  logic [areg_w-1:0] rec_rd    [rob_depth];
  logic             rec_writes [rob_depth];

  logic [rob_ptr_w-1:0] head;
  logic [rob_ptr_w-1:0] tail;
  logic [cnt_w-1:0]     count;
  logic [cnt_w-1:0]     free_slots;

  logic                 issue_en [2];
  logic [rob_ptr_w-1:0] wr_ptr [2];
  logic [1:0]           n_alloc;
  logic                 cdb_match [2][rob_depth];

  logic head_request;
  logic head_is_jump;
  logic pop;
  logic bus_granted;
  logic bus_selected;
  logic mispredict;
  logic spec_clear;
  logic spec_flush;

  // ##################################################
  // allocation and occupancy
  // ##################################################

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      issue_en[i] = (issue_class[i] != none);
    end
  end

  assign n_alloc   = {1'b0, issue_en[0]} + {1'b0, issue_en[1]};
  assign wr_ptr[0] = tail;
  assign wr_ptr[1] = issue_en[0] ? tail + rob_ptr_w'(1) : tail;  // port 0 is older.

  assign free_slots = cnt_w'(rob_depth) - count;
  assign full       = (free_slots < cnt_w'(2));

  always_ff @(posedge global_bus) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + rob_ptr_w'(pop);
      tail  <= tail + rob_ptr_w'(n_alloc);
      count <= count + cnt_w'(n_alloc) - cnt_w'(pop);
    end
  end

  // ##################################################
  // record state
  // ##################################################

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      for (int j = 0; j < rob_depth; j++) begin
        cdb_match[i][j] = cdb_valid[i] && (rec_status[j] == waiting) &&
                          (rec_pc[j] == cdb_pc[i]);
      end
    end
  end

  assign spec_clear = bus_granted && head_is_jump && !mispredict;
  assign spec_flush = mispredict;

  always_ff @(posedge global_bus) begin
    if (rst) begin
      for (int j = 0; j < rob_depth; j++) begin
        rec_status[j] <= empty_slot;
        rec_spec[j]   <= 1'b0;
      end
    end else begin
      for (int j = 0; j < rob_depth; j++) begin
        for (int i = 0; i < 2; i++) begin
          if (cdb_match[i][j]) rec_status[j] <= completed;
        end
        if (rec_spec[j] && spec_flush) begin
          rec_status[j] <= ignore;  // flush wins over a late completion.
          rec_spec[j]   <= 1'b0;
        end else if (rec_spec[j] && spec_clear) begin
          rec_spec[j] <= 1'b0;
        end
      end
      for (int i = 0; i < 2; i++) begin
        if (issue_en[i]) begin
          rec_status[wr_ptr[i]] <= (issue_spec[i] && spec_flush) ? ignore : waiting;
          rec_spec[wr_ptr[i]]   <= issue_spec[i] && !spec_flush && !spec_clear;
        end
      end
      if (pop) rec_status[head] <= empty_slot;
    end
  end

  always_ff @(posedge global_bus) begin
    for (int j = 0; j < rob_depth; j++) begin
      for (int i = 0; i < 2; i++) begin
        if (cdb_match[i][j]) begin
          rec_result[j] <= cdb_result[i];
          rec_target[j] <= cdb_jmp_target[i];
        end
      end
    end
    for (int i = 0; i < 2; i++) begin
      if (issue_en[i]) begin
        rec_class[wr_ptr[i]]  <= issue_class[i];
        rec_pc[wr_ptr[i]]     <= issue_pc[i];
        rec_rd[wr_ptr[i]]     <= issue_rd[i];
        rec_writes[wr_ptr[i]] <= issue_writes[i];
      end
    end
  end

  // ##################################################
  // head retirement
  // ##################################################

  assign head_request = (rec_status[head] == completed);
  assign head_is_jump = (rec_class[head] == jump);
  assign pop          = (rec_status[head] == ignore) || bus_granted;

  commit_arbiter i_commit_arbiter (
    .global_bus   (global_bus),
    .rst          (rst),
    .head_request (head_request),
    .commit_busy  (commit_busy),
    .bus_granted  (bus_granted),
    .bus_selected (bus_selected)
  );

  jump_resolver i_jump_resolver (
    .global_bus     (global_bus),
    .rst            (rst),
    .bus_granted    (bus_granted),
    .head_is_jump   (head_is_jump),
    .head_pc        (rec_pc[head]),
    .head_target    (rec_target[head]),
    .mispredict     (mispredict),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .clear_tag      (clear_tag),
    .delete_tag     (delete_tag)
  );

  for (genvar i = 0; i < 2; i++) begin : g_commit
    always_ff @(posedge global_bus) begin
      if (rst || !(bus_granted && (bus_selected == 1'(i)))) begin
        commit_valid[i]     <= 1'b0;  // idle bus reads as zero.
        commit_pc[i]        <= '0;
        commit_result[i]    <= '0;
        commit_rd[i]        <= '0;
        commit_reg_write[i] <= 1'b0;
        commit_mem_write[i] <= 1'b0;
      end else begin
        commit_valid[i]     <= 1'b1;
        commit_pc[i]        <= rec_pc[head];
        commit_result[i]    <= rec_result[head];
        commit_rd[i]        <= rec_rd[head];
        commit_reg_write[i] <= rec_writes[head];
        commit_mem_write[i] <= (rec_class[head] == mem) && rec_writes[head];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top (
  input  logic                       global_bus,
  input  logic                       rst,
  input  rob_pkg::instr_class_e      issue_class [2],
  input  logic [rob_pkg::xlen-1:0]   issue_pc [2],
  input  logic [rob_pkg::areg_w-1:0] issue_rd [2],
  input  logic                       issue_writes [2],
  input  logic                       issue_spec [2],
  input  logic                       cdb_valid [2],
  input  logic [rob_pkg::xlen-1:0]   cdb_pc [2],
  input  logic [rob_pkg::xlen-1:0]   cdb_result [2],
  input  logic [rob_pkg::xlen-1:0]   cdb_jmp_target [2],
  input  logic                       commit_busy [2],
  output logic                       commit_valid [2],
  output logic [rob_pkg::xlen-1:0]   commit_pc [2],
  output logic [rob_pkg::xlen-1:0]   commit_result [2],
  output logic [rob_pkg::areg_w-1:0] commit_rd [2],
  output logic                       commit_reg_write [2],
  output logic                       commit_mem_write [2],
  output logic                       redirect_valid,
  output logic [rob_pkg::xlen-1:0]   redirect_pc,
  output logic                       clear_tag,
  output logic                       delete_tag,
  output logic                       full
);

  // ##################################################
  // retirement block
  // ##################################################

  reorder_buffer i_reorder_buffer (
    .global_bus       (global_bus),
    .rst              (rst),
    .issue_class      (issue_class),
    .issue_pc         (issue_pc),
    .issue_rd         (issue_rd),
    .issue_writes     (issue_writes),
    .issue_spec       (issue_spec),
    .cdb_valid        (cdb_valid),
    .cdb_pc           (cdb_pc),
    .cdb_result       (cdb_result),
    .cdb_jmp_target   (cdb_jmp_target),
    .commit_busy      (commit_busy),
    .commit_valid     (commit_valid),
    .commit_pc        (commit_pc),
    .commit_result    (commit_result),
    .commit_rd        (commit_rd),
    .commit_reg_write (commit_reg_write),
    .commit_mem_write (commit_mem_write),
    .redirect_valid   (redirect_valid),
    .redirect_pc      (redirect_pc),
    .clear_tag        (clear_tag),
    .delete_tag       (delete_tag),
    .full             (full)
  );

endmodule

`default_nettype wire

//--- sim/rob_props.sv
`timescale 1ns/1ps
`default_nettype none

module rob_props (
  input logic global_bus,
  input logic rst,
  input logic commit_valid [2],
  input logic redirect_valid,
  input logic clear_tag,
  input logic delete_tag
);

  // ##################################################
  // output rules
  // ##################################################

  one_bus: assert property (@(posedge global_bus) disable iff (rst)
    !(commit_valid[0] && commit_valid[1]))
    else $error("commit_valid high on both buses");

  redirect_del: assert property (@(posedge global_bus) disable iff (rst)
    redirect_valid |-> delete_tag)
    else $error("redirect_valid without delete_tag");

  tags_excl: assert property (@(posedge global_bus) disable iff (rst)
    !(clear_tag && delete_tag))
    else $error("clear_tag and delete_tag together");

  // outputs are registered, so look one edge after reset.
  no_reset_commit: assert property (@(posedge global_bus)
    rst |=> !(commit_valid[0] || commit_valid[1]))
    else $error("commit during reset");

endmodule

`default_nettype wire

//--- sim/tb_rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rob_top;
  import rob_pkg::*;

  localparam int n_instr   = 400;
  localparam int max_cycle = n_instr * 20;

  typedef struct {
    logic [xlen-1:0]   pc;
    instr_class_e      cls;
    logic [areg_w-1:0] rd;
    logic              writes;
    logic              spec;
    rob_status_e       status;
    logic [xlen-1:0]   result;
    logic [xlen-1:0]   target;
  } rec_t;

  logic              global_bus;
  logic              rst;
  instr_class_e      issue_class [2];
  logic [xlen-1:0]   issue_pc [2];
  logic [areg_w-1:0] issue_rd [2];
  logic              issue_writes [2];
  logic              issue_spec [2];
  logic              cdb_valid [2];
  logic [xlen-1:0]   cdb_pc [2];
  logic [xlen-1:0]   cdb_result [2];
  logic [xlen-1:0]   cdb_jmp_target [2];
  logic              commit_busy [2];
  logic              commit_valid [2];
  logic [xlen-1:0]   commit_pc [2];
  logic [xlen-1:0]   commit_result [2];
  logic [areg_w-1:0] commit_rd [2];
  logic              commit_reg_write [2];
  logic              commit_mem_write [2];
  logic              redirect_valid;
  logic [xlen-1:0]   redirect_pc;
  logic              clear_tag;
  logic              delete_tag;
  logic              full;

  // reference model state.
  rec_t        q[$];
  int          waiting_idx[$];
  rec_t        h;
  rec_t        r;
  logic [15:0] lfsr_state = 16'd53594;
  logic        rr_last;
  logic        jump_pending;
  logic        mis;
  logic        clr;
  logic        sel;
  logic        spec_bit;
  instr_class_e cls;
  logic [31:0] rnd;
  logic [xlen-1:0] next_pc;
  int          issued;
  int          cycles;
  int          drain;
  int          pick;
  int          k;
  logic        exp_cv [2];
  logic [xlen-1:0] exp_pc [2];
  logic [xlen-1:0] exp_res [2];
  logic [areg_w-1:0] exp_rd [2];
  logic        exp_rw [2];
  logic        exp_mw [2];
  logic        exp_redir;
  logic [xlen-1:0] exp_rpc;
  logic        exp_clr;
  logic        exp_del;
  logic        exp_full;

  rob_top i_dut (.*);

  bind reorder_buffer rob_props i_rob_props (
    .global_bus     (global_bus),
    .rst            (rst),
    .commit_valid   (commit_valid),
    .redirect_valid (redirect_valid),
    .clear_tag      (clear_tag),
    .delete_tag     (delete_tag)
  );

  // ##################################################
  // helpers
  // ##################################################

  // taps 16, 14, 13, 11.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int b = 0; b < n; b++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic clear_expect();
    for (int b = 0; b < 2; b++) begin
      exp_cv[b]  = 1'b0;
      exp_pc[b]  = '0;
      exp_res[b] = '0;
      exp_rd[b]  = '0;
      exp_rw[b]  = 1'b0;
      exp_mw[b]  = 1'b0;
    end
    exp_redir = 1'b0;
    exp_rpc   = '0;
    exp_clr   = 1'b0;
    exp_del   = 1'b0;
  endtask

  initial begin
    global_bus = 1'b0;
    forever #4 global_bus = ~global_bus;
  end

  initial begin
    rst = 1'b1;
    for (int i = 0; i < 2; i++) begin
      issue_class[i]    = none;
      issue_pc[i]       = '0;
      issue_rd[i]       = '0;
      issue_writes[i]   = 1'b0;
      issue_spec[i]     = 1'b0;
      cdb_valid[i]      = 1'b0;
      cdb_pc[i]         = '0;
      cdb_result[i]     = '0;
      cdb_jmp_target[i] = '0;
      commit_busy[i]    = 1'b0;
    end
    repeat (3) @(posedge global_bus);
    rst <= 1'b0;
  end

  // ##################################################
  // check, model step, drive
  // ##################################################

  always @(posedge global_bus) begin
    if (rst) begin
      q.delete();
      rr_last      = 1'b1;  // bus 0 wins the first tie.
      jump_pending = 1'b0;
      next_pc      = 32'h0000_1000;
      issued       = 0;
      cycles       = 0;
      drain        = 0;
      exp_full     = 1'b0;
      clear_expect();
    end else begin
      for (int b = 0; b < 2; b++) begin
        check_value($sformatf("commit_valid[%0d]", b), 32'(commit_valid[b]), 32'(exp_cv[b]));
        check_value($sformatf("commit_pc[%0d]", b), commit_pc[b], exp_pc[b]);
        check_value($sformatf("commit_result[%0d]", b), commit_result[b], exp_res[b]);
        check_value($sformatf("commit_rd[%0d]", b), 32'(commit_rd[b]), 32'(exp_rd[b]));
        check_value($sformatf("commit_reg_write[%0d]", b), 32'(commit_reg_write[b]),
                    32'(exp_rw[b]));
        check_value($sformatf("commit_mem_write[%0d]", b), 32'(commit_mem_write[b]),
                    32'(exp_mw[b]));
      end
      check_value("redirect_valid", 32'(redirect_valid), 32'(exp_redir));
      check_value("redirect_pc", redirect_pc, exp_rpc);
      check_value("clear_tag", 32'(clear_tag), 32'(exp_clr));
      check_value("delete_tag", 32'(delete_tag), 32'(exp_del));
      check_value("full", 32'(full), 32'(exp_full));

      // retirement at the head.
      clear_expect();
      mis = 1'b0;
      clr = 1'b0;
      if (q.size() > 0 && q[0].status == ignore) begin
        void'(q.pop_front());  // dropped without commit.
      end else if (q.size() > 0 && q[0].status == completed &&
                   !(commit_busy[0] && commit_busy[1])) begin
        if (commit_busy[0]) sel = 1'b1;
        else if (commit_busy[1]) sel = 1'b0;
        else sel = !rr_last;
        rr_last = sel;
        h = q.pop_front();
        exp_cv[sel]  = 1'b1;
        exp_pc[sel]  = h.pc;
        exp_res[sel] = h.result;
        exp_rd[sel]  = h.rd;
        exp_rw[sel]  = h.writes;
        exp_mw[sel]  = (h.cls == mem) && h.writes;
        if (h.cls == jump) begin
          mis          = (h.target != h.pc + 32'd4);
          clr          = !mis;
          exp_redir    = mis;
          exp_rpc      = mis ? h.target : '0;
          exp_del      = mis;
          exp_clr      = clr;
          jump_pending = 1'b0;
        end
      end

      // completions, then flush or clear, then allocation.
      for (int i = 0; i < 2; i++) begin
        if (cdb_valid[i]) begin
          foreach (q[j]) begin
            if (q[j].status == waiting && q[j].pc == cdb_pc[i]) begin
              q[j].status = completed;
              q[j].result = cdb_result[i];
              q[j].target = cdb_jmp_target[i];
            end
          end
        end
      end
      foreach (q[j]) begin
        if (q[j].spec && mis) begin
          q[j].status = ignore;
          q[j].spec   = 1'b0;
        end else if (q[j].spec && clr) begin
          q[j].spec = 1'b0;
        end
      end
      for (int i = 0; i < 2; i++) begin
        if (issue_class[i] != none) begin
          r.pc     = issue_pc[i];
          r.cls    = issue_class[i];
          r.rd     = issue_rd[i];
          r.writes = issue_writes[i];
          r.status = (issue_spec[i] && mis) ? ignore : waiting;
          r.spec   = issue_spec[i] && !mis && !clr;
          r.result = '0;
          r.target = '0;
          q.push_back(r);
        end
      end
      exp_full = (q.size() > rob_depth - 2);

      // new stimulus.
      for (int i = 0; i < 2; i++) begin
        cls      = none;
        spec_bit = jump_pending;
        if (issued < n_instr && q.size() <= rob_depth - 2 && rand_bits(1) == 32'd1) begin
          rnd = rand_bits(2);
          cls = instr_class_e'(rnd[1:0]);
          if (cls == none) cls = alu;
          if (cls == jump && jump_pending) cls = alu;  // one jump in flight.
          if (cls == jump) jump_pending = 1'b1;
          issued++;
        end
        rnd = rand_bits(6);
        issue_class[i]  <= cls;
        issue_pc[i]     <= next_pc;
        issue_rd[i]     <= rnd[4:0];
        issue_writes[i] <= rnd[5];
        issue_spec[i]   <= spec_bit && (cls != none);
        if (cls != none) next_pc = next_pc + 32'd4;
      end
      waiting_idx.delete();
      foreach (q[j]) begin
        if (q[j].status == waiting) waiting_idx.push_back(j);
      end
      for (int i = 0; i < 2; i++) begin
        cdb_valid[i] <= 1'b0;
        if (waiting_idx.size() > 0 && rand_bits(1) == 32'd1) begin
          pick = int'(rand_bits(4)) % waiting_idx.size();
          k    = waiting_idx[pick];
          waiting_idx.delete(pick);
          cdb_valid[i]      <= 1'b1;
          cdb_pc[i]         <= q[k].pc;
          cdb_result[i]     <= rand_bits(32);
          cdb_jmp_target[i] <= (rand_bits(1) == 32'd1) ? q[k].pc + 32'd4 : rand_bits(32);
        end
      end
      rnd = rand_bits(2);
      commit_busy[0] <= rnd[0];
      commit_busy[1] <= rnd[1];

      cycles++;
      if (issued == n_instr && q.size() == 0) drain++;
      if (cycles > max_cycle) begin
        $display("timeout after %0d cycles with %0d records left", cycles, q.size());
        $display("TEST RESULT: FAIL");
        $fatal(1, "run did not drain");
      end else if (drain >= 3) begin
        $display("TEST RESULT: PASS");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

//--- flist.f
common/rob_pkg.sv
reorder_buffer/commit_arbiter.sv
reorder_buffer/jump_resolver.sv
reorder_buffer/reorder_buffer.sv
hdl/rob_top.sv
sim/rob_props.sv
sim/tb_rob_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_rob_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
